/* filelist.f */
logic/rv_fetch_pkg.sv
logic/fetch_bus_if.sv
logic/pc_sequencer.sv
logic/branch_target_buffer.sv
logic/instr_ram.sv
logic/fetch_stage_bram.sv
logic/if_id_register.sv
logic/fetch_top.sv
testbench/fetch_tb.sv

/* logic/branch_target_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

module branch_target_buffer import rv_fetch_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   update_en,
  input  logic   update_taken,
  input  xaddr_t lookup_pc,
  input  xaddr_t update_pc,
  input  xaddr_t update_target,
  output logic   hit,
  output logic   pred_taken,
  output xaddr_t target
);

  // Entry storage
  // Only the valid bits are control state and the payload arrays hold data
  logic [BTB_ENTRIES-1:0] entry_valid;
  btb_tag_t               entry_tag    [BTB_ENTRIES];
  xaddr_t                 entry_target [BTB_ENTRIES];
  logic                   entry_taken  [BTB_ENTRIES];

  btb_index_t lookup_index;
  btb_tag_t   lookup_tag;
  btb_index_t update_index;
  btb_tag_t   update_tag;

  // Split both addresses into index and tag
  // Bits 1 and 0 are the byte offset of a word and never reach the table
  assign lookup_index = lookup_pc[BTB_INDEX_BITS+1:2];
  assign lookup_tag   = lookup_pc[XLEN-1:BTB_INDEX_BITS+2];
  assign update_index = update_pc[BTB_INDEX_BITS+1:2];
  assign update_tag   = update_pc[XLEN-1:BTB_INDEX_BITS+2];

  // Combinational lookup on the current pc
  // A hit needs a valid entry whose tag matches the upper pc bits
  always_comb begin
    hit        = entry_valid[lookup_index] && (entry_tag[lookup_index] == lookup_tag);
    // A stale taken bit in a missing entry must not leak out
    pred_taken = hit && entry_taken[lookup_index];
    target     = entry_target[lookup_index];
  end

  // Valid bits clear on reset and are set by every update
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      entry_valid <= '0;
    end else if (update_en) begin
      entry_valid[update_index] <= 1'b1;
    end
  end

  // Payload fields for the updated entry
  // A new branch simply replaces whatever aliased into the same slot
  always_ff @(posedge clk) begin
    if (update_en) begin
      entry_tag[update_index]    <= update_tag;
      entry_target[update_index] <= update_target;
      entry_taken[update_index]  <= update_taken;
    end
  end

  // The sequencer trusts pred_taken only together with hit
  a_taken_implies_hit: assert property (
    @(posedge clk) disable iff (!rst_n)
    pred_taken |-> hit
  ) else $error("branch_target_buffer: pred_taken without hit");

  // An update must be visible to a lookup of the same pc on the next cycle
  a_update_visible: assert property (
    @(posedge clk) disable iff (!rst_n)
    update_en ##1 (lookup_pc == $past(update_pc))
    |-> hit && (target == $past(update_target))
  ) else $error("branch_target_buffer: update not visible one cycle later");

endmodule

`default_nettype wire

/* logic/fetch_bus_if.sv */
`timescale 1ns/10ps
`default_nettype none

// Carries one fetched slot from the BRAM fetch stage to the IF/ID register
interface fetch_bus_if import rv_fetch_pkg::*; ();

  // Address that was read from the instruction RAM
  xaddr_t pc;
  xaddr_t pc_plus4;

  // Prediction buffered alongside that fetch address
  logic   btb_hit;
  logic   btb_pred_taken;
  xaddr_t btb_target;

  // The fetch stage owns every field
  modport source (
    output pc, pc_plus4, btb_hit, btb_pred_taken, btb_target
  );

  // The IF/ID register only samples them
  modport sink (
    input pc, pc_plus4, btb_hit, btb_pred_taken, btb_target
  );

endinterface

`default_nettype wire

/* logic/fetch_stage_bram.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_stage_bram import rv_fetch_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   if_id_stall,
  input  logic   if_id_flush,
  input  logic   btb_hit_if,
  input  logic   btb_pred_taken_if,
  input  xaddr_t pc,
  input  xaddr_t pc_next,
  input  xaddr_t btb_target_if,
  output logic   imem_ren,
  output xaddr_t imem_raddr,
  input  instr_t imem_rdata,
  output instr_t instr_id,
  fetch_bus_if.source fetch_bus
);

  // Buffers that line the fetch address up with the RAM output
  xaddr_t pc_buf;
  xaddr_t pc_plus4_buf;
  logic   btb_hit_buf;
  logic   btb_pred_taken_buf;
  xaddr_t btb_target_buf;

  // Instruction word after the RAM latency
  instr_t instr_buf;

  // Early fetch reads pc_next, so a predicted or redirected target is
  // requested in the same cycle it is chosen and no extra flush is needed
  assign imem_raddr = BPRED_EARLY_FETCH ? pc_next : pc;

  // Reading stays enabled through reset so the reset vector is in flight
  // A stall drops the enable and the RAM keeps presenting the same word
  assign imem_ren = !rst_n || !if_id_stall;

  // Fetch address and prediction buffers
  // They capture exactly what was sent to the RAM so the word and its
  // address match even when pc and pc_next disagree around a stall
  // A flush does not stop them and only the instruction is squashed
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_buf             <= RESET_PC;
      pc_plus4_buf       <= RESET_PC + INSTR_BYTES;
      btb_hit_buf        <= 1'b0;
      btb_pred_taken_buf <= 1'b0;
      btb_target_buf     <= '0;
    end else if (!if_id_stall) begin
      pc_buf             <= imem_raddr;
      pc_plus4_buf       <= imem_raddr + INSTR_BYTES;
      btb_hit_buf        <= btb_hit_if;
      btb_pred_taken_buf <= btb_pred_taken_if;
      btb_target_buf     <= btb_target_if;
    end
  end

  // Instruction buffer
  // Flush beats stall here, so a redirect squashes the slot even when frozen
  always_ff @(posedge clk) begin
    if (!rst_n || if_id_flush) begin
      instr_buf <= I_NOP;
    end else if (!if_id_stall) begin
      instr_buf <= imem_rdata;
    end
  end

  assign instr_id = instr_buf;

  // Fields travelling on to the IF/ID register
  assign fetch_bus.pc             = pc_buf;
  assign fetch_bus.pc_plus4       = pc_plus4_buf;
  assign fetch_bus.btb_hit        = btb_hit_buf;
  assign fetch_bus.btb_pred_taken = btb_pred_taken_buf;
  assign fetch_bus.btb_target     = btb_target_buf;

  // Every address handed to the RAM must be a word address
  a_fetch_aligned: assert property (
    @(posedge clk) imem_ren |-> imem_raddr[1:0] == 2'b00
  ) else $error("fetch_stage_bram: misaligned fetch address %h", imem_raddr);

endmodule

`default_nettype wire

/* logic/fetch_top.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_top import rv_fetch_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   stall,
  input  logic   redirect,
  input  logic   btb_update_en,
  input  logic   btb_update_taken,
  input  logic   imem_wen,
  input  xaddr_t redirect_pc,
  input  xaddr_t btb_update_pc,
  input  xaddr_t btb_update_target,
  input  xaddr_t imem_waddr,
  input  instr_t imem_wdata,
  output instr_t instr_id,
  output xaddr_t pc_id,
  output xaddr_t pc_plus4_id,
  output xaddr_t btb_target_id,
  output logic   btb_hit_id,
  output logic   btb_pred_taken_id
);

  // Sequencer state and its lookahead
  xaddr_t pc;
  xaddr_t pc_next;

  // Live BTB answer for the current pc
  logic   btb_hit;
  logic   btb_pred_taken;
  xaddr_t btb_target;

  // Instruction RAM read port
  logic   imem_ren;
  xaddr_t imem_raddr;
  instr_t imem_rdata;

  // Fetch stage to IF/ID register
  fetch_bus_if fetch_bus ();

  // One stall level freezes the pc, the fetch buffers and the IF/ID register
  pc_sequencer u_pc_sequencer (
    .clk            (clk),
    .rst_n          (rst_n),
    .stall          (stall),
    .redirect       (redirect),
    .btb_hit        (btb_hit),
    .btb_pred_taken (btb_pred_taken),
    .redirect_pc    (redirect_pc),
    .btb_target     (btb_target),
    .pc             (pc),
    .pc_next        (pc_next)
  );

  // Predicts from the current pc and learns from resolved branches
  branch_target_buffer u_btb (
    .clk           (clk),
    .rst_n         (rst_n),
    .update_en     (btb_update_en),
    .update_taken  (btb_update_taken),
    .lookup_pc     (pc),
    .update_pc     (btb_update_pc),
    .update_target (btb_update_target),
    .hit           (btb_hit),
    .pred_taken    (btb_pred_taken),
    .target        (btb_target)
  );

  instr_ram u_instr_ram (
    .clk   (clk),
    .ren   (imem_ren),
    .wen   (imem_wen),
    .raddr (imem_raddr),
    .waddr (imem_waddr),
    .wdata (imem_wdata),
    .rdata (imem_rdata)
  );

  // A redirect also squashes the slot that is already on its way
  fetch_stage_bram u_fetch_stage (
    .clk               (clk),
    .rst_n             (rst_n),
    .if_id_stall       (stall),
    .if_id_flush       (redirect),
    .btb_hit_if        (btb_hit),
    .btb_pred_taken_if (btb_pred_taken),
    .pc                (pc),
    .pc_next           (pc_next),
    .btb_target_if     (btb_target),
    .imem_ren          (imem_ren),
    .imem_raddr        (imem_raddr),
    .imem_rdata        (imem_rdata),
    .instr_id          (instr_id),
    .fetch_bus         (fetch_bus.source)
  );

  if_id_register u_if_id (
    .clk               (clk),
    .rst_n             (rst_n),
    .stall             (stall),
    .fetch_bus         (fetch_bus.sink),
    .pc_id             (pc_id),
    .pc_plus4_id       (pc_plus4_id),
    .btb_target_id     (btb_target_id),
    .btb_hit_id        (btb_hit_id),
    .btb_pred_taken_id (btb_pred_taken_id)
  );

endmodule

`default_nettype wire

/* logic/if_id_register.sv */
`timescale 1ns/10ps
`default_nettype none

module if_id_register import rv_fetch_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   stall,
  fetch_bus_if.sink fetch_bus,
  output xaddr_t pc_id,
  output xaddr_t pc_plus4_id,
  output xaddr_t btb_target_id,
  output logic   btb_hit_id,
  output logic   btb_pred_taken_id
);

  // One more cycle on the address side
  // The instruction spends that cycle in the RAM, so both sides meet here
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_id             <= RESET_PC;
      pc_plus4_id       <= RESET_PC + INSTR_BYTES;
      btb_hit_id        <= 1'b0;
      btb_pred_taken_id <= 1'b0;
      btb_target_id     <= '0;
    end else if (!stall) begin
      pc_id             <= fetch_bus.pc;
      pc_plus4_id       <= fetch_bus.pc_plus4;
      btb_hit_id        <= fetch_bus.btb_hit;
      btb_pred_taken_id <= fetch_bus.btb_pred_taken;
      btb_target_id     <= fetch_bus.btb_target;
    end
  end

  // The increment is computed in the fetch stage, so check it survives the hop
  a_plus4_consistent: assert property (
    @(posedge clk) disable iff (!rst_n)
    pc_plus4_id == pc_id + INSTR_BYTES
  ) else $error("if_id_register: pc_plus4_id %h for pc_id %h", pc_plus4_id, pc_id);

endmodule

`default_nettype wire

/* logic/instr_ram.sv */
`timescale 1ns/10ps
`default_nettype none

module instr_ram import rv_fetch_pkg::*; (
  input  logic   clk,
  input  logic   ren,
  input  logic   wen,
  input  xaddr_t raddr,
  input  xaddr_t waddr,
  input  instr_t wdata,
  output instr_t rdata
);

  // Word array, like block RAM it comes up with unknown contents
  instr_t mem [IMEM_DEPTH];

  imem_index_t read_index;
  imem_index_t write_index;

  // Word indices from byte addresses
  // Upper address bits wrap, since the memory covers only 1 KiB
  assign read_index  = raddr[IMEM_ADDR_BITS+1:2];
  assign write_index = waddr[IMEM_ADDR_BITS+1:2];

  // Write port for loading a program, one word per cycle
  always_ff @(posedge clk) begin
    if (wen) begin
      mem[write_index] <= wdata;
    end
  end

  // Registered read port
  // Data appears one cycle after the address and holds while ren is low
  // A read and write to the same word in one cycle returns the old word
  always_ff @(posedge clk) begin
    if (ren) begin
      rdata <= mem[read_index];
    end
  end

  // The fetch path presents word addresses only
  a_read_aligned: assert property (
    @(posedge clk) ren |-> raddr[1:0] == 2'b00
  ) else $error("instr_ram: misaligned read address %h", raddr);

endmodule

`default_nettype wire

/* logic/pc_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module pc_sequencer import rv_fetch_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   stall,
  input  logic   redirect,
  input  logic   btb_hit,
  input  logic   btb_pred_taken,
  input  xaddr_t redirect_pc,
  input  xaddr_t btb_target,
  output xaddr_t pc,
  output xaddr_t pc_next
);

  // A prediction only steers fetch when the entry hit and says taken
  logic predict_taken;

  assign predict_taken = btb_hit && btb_pred_taken;

  // Next fetch address
  // A back-end redirect always wins since it corrects a wrong path
  // A taken BTB hit comes next and otherwise fetch runs sequentially
  always_comb begin
    if (!rst_n) begin
      // The last reset cycle already fetches the reset vector
      pc_next = RESET_PC;
    end else if (redirect) begin
      pc_next = redirect_pc;
    end else if (predict_taken) begin
      pc_next = btb_target;
    end else begin
      pc_next = pc + INSTR_BYTES;
    end
  end

  // Architectural fetch pc
  // It follows pc_next one cycle later and freezes while the front end stalls
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= RESET_PC;
    end else if (!stall) begin
      pc <= pc_next;
    end
  end

  // Both the held pc and the chosen next address must stay on word boundaries
  // A misaligned redirect or BTB target from outside would break the RAM index
  a_pc_word_aligned: assert property (
    @(posedge clk) disable iff (!rst_n)
    (pc[1:0] == 2'b00) && (pc_next[1:0] == 2'b00)
  ) else $error("pc_sequencer: misaligned pc %h or pc_next %h", pc, pc_next);

endmodule

`default_nettype wire

/* logic/rv_fetch_pkg.sv */
`default_nettype none

package rv_fetch_pkg;

  // Architectural width of addresses on the fetch path
  localparam int XLEN = 32;

  // Byte address used for pc values and branch targets
  typedef logic [XLEN-1:0] xaddr_t;

  // One 32-bit instruction word, compressed encodings are not supported
  typedef logic [31:0] instr_t;

  // Every instruction is one word, so sequential fetch steps by four bytes
  localparam xaddr_t INSTR_BYTES = 32'd4;

  // Canonical addi x0,x0,0 that fills a flushed slot
  localparam instr_t I_NOP = 32'h0000_0013;

  // Address fetched while reset is held
  localparam xaddr_t RESET_PC = 32'h0000_0000;

  // Branch target buffer geometry
  // The index sits just above the two byte-offset bits and the tag is the rest
  localparam int BTB_INDEX_BITS = 4;
  localparam int BTB_ENTRIES = 1 << BTB_INDEX_BITS;
  localparam int BTB_TAG_BITS = XLEN - BTB_INDEX_BITS - 2;
  typedef logic [BTB_INDEX_BITS-1:0] btb_index_t;
  typedef logic [BTB_TAG_BITS-1:0] btb_tag_t;

  // Instruction memory geometry, word indexed by address bits 9 down to 2
  localparam int IMEM_ADDR_BITS = 8;
  localparam int IMEM_DEPTH = 1 << IMEM_ADDR_BITS;
  typedef logic [IMEM_ADDR_BITS-1:0] imem_index_t;

  // Fetch from pc_next so a predicted target is read in the cycle it is chosen
  localparam bit BPRED_EARLY_FETCH = 1'b1;

endpackage

`default_nettype wire

/* testbench/fetch_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_tb import rv_fetch_pkg::*; ();

  localparam int HALF_PERIOD = 4;
  localparam int RESET_CYCLES = 5;
  // Stimulus after reset release takes about this many cycles
  localparam int RUN_CYCLES = 180;
  // The program load costs one cycle per word on top of reset and stimulus
  localparam int MAX_CYCLES = IMEM_DEPTH + RESET_CYCLES + 2 * RUN_CYCLES;
  localparam int OUT_BITS = 4 * XLEN + 2;
  // Trained branch and its target
  // The target also shares the branch's BTB index
  localparam xaddr_t BRANCH_PC = 32'h0000_0040;
  localparam xaddr_t BRANCH_TARGET = 32'h0000_0080;

  logic   clk;
  logic   rst_n;
  logic   stall;
  logic   redirect;
  logic   btb_update_en;
  logic   btb_update_taken;
  logic   imem_wen;
  xaddr_t redirect_pc;
  xaddr_t btb_update_pc;
  xaddr_t btb_update_target;
  xaddr_t imem_waddr;
  instr_t imem_wdata;
  instr_t instr_id;
  xaddr_t pc_id;
  xaddr_t pc_plus4_id;
  xaddr_t btb_target_id;
  logic   btb_hit_id;
  logic   btb_pred_taken_id;

  integer seed;
  int     error_count;
  int     cycle_count;
  int     redirect_count;
  int     stall_cycles;
  // Set once the BTB holds the taken entry for BRANCH_PC
  logic   btb_trained;

  // All outputs side by side, and the same as they stood one cycle earlier
  logic [OUT_BITS-1:0] id_out;
  logic [OUT_BITS-1:0] prev_out;
  xaddr_t              prev_pc;

  fetch_top dut0 (
    .clk               (clk),
    .rst_n             (rst_n),
    .stall             (stall),
    .redirect          (redirect),
    .btb_update_en     (btb_update_en),
    .btb_update_taken  (btb_update_taken),
    .imem_wen          (imem_wen),
    .redirect_pc       (redirect_pc),
    .btb_update_pc     (btb_update_pc),
    .btb_update_target (btb_update_target),
    .imem_waddr        (imem_waddr),
    .imem_wdata        (imem_wdata),
    .instr_id          (instr_id),
    .pc_id             (pc_id),
    .pc_plus4_id       (pc_plus4_id),
    .btb_target_id     (btb_target_id),
    .btb_hit_id        (btb_hit_id),
    .btb_pred_taken_id (btb_pred_taken_id)
  );

  initial clk = 1'b0;
  always #HALF_PERIOD clk = ~clk;

  // Program word for a byte address: a fixed upper half over the word address
  function automatic instr_t stored_word(input xaddr_t addr);
    return {16'hA5C3, 16'(addr[IMEM_ADDR_BITS+1:2])};
  endfunction

  assign id_out = {instr_id, pc_id, pc_plus4_id, btb_target_id, btb_hit_id, btb_pred_taken_id};

  // One-deep shadow of the outputs
  always @(posedge clk) begin
    prev_out <= id_out;
    prev_pc  <= pc_id;
  end

  // Cycle counter that ends a run which never reaches its summary
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, the stimulus never finished", cycle_count);
      $display("Checks failed");
      $finish;
    end
  end

  // Writes every word of the instruction RAM, one per cycle
  task automatic load_program();
    for (int i = 0; i < IMEM_DEPTH; i++) begin
      @(negedge clk);
      imem_wen   = 1'b1;
      imem_waddr = xaddr_t'(i) << 2;
      imem_wdata = stored_word(xaddr_t'(i) << 2);
    end
    @(negedge clk);
    imem_wen = 1'b0;
  endtask

  // Free-running fetch with no stall and no redirect
  task automatic run_cycles(input int n);
    repeat (n) begin
      @(negedge clk);
      stall    = 1'b0;
      redirect = 1'b0;
    end
  endtask

  // Stall bursts of one to four cycles start at random
  task automatic run_random_stalls(input int n);
    int burst;
    burst = 0;
    repeat (n) begin
      @(negedge clk);
      redirect = 1'b0;
      if (burst == 0 && ($random(seed) & 3) == 0) begin
        burst = 1 + ($random(seed) & 3);
      end
      stall = (burst != 0);
      if (burst != 0) begin
        burst--;
        stall_cycles++;
      end
    end
    @(negedge clk);
    stall = 1'b0;
  endtask

  // One-cycle redirect pulse, redirect_pc keeps its value afterwards
  task automatic pulse_redirect(input xaddr_t target);
    @(negedge clk);
    stall       = 1'b0;
    redirect    = 1'b1;
    redirect_pc = target;
    @(negedge clk);
    redirect = 1'b0;
    redirect_count++;
  endtask

  // Redirect that lands while the front end is frozen
  task automatic flush_while_stalled(input xaddr_t target);
    @(negedge clk);
    stall       = 1'b1;
    redirect    = 1'b1;
    redirect_pc = target;
    @(negedge clk);
    redirect = 1'b0;
    @(negedge clk);
    stall = 1'b0;
    redirect_count++;
    stall_cycles += 2;
  endtask

  // Installs one taken entry as a resolved branch would
  task automatic train_btb(input xaddr_t branch_pc, input xaddr_t target);
    @(negedge clk);
    btb_update_en     = 1'b1;
    btb_update_taken  = 1'b1;
    btb_update_pc     = branch_pc;
    btb_update_target = target;
    @(negedge clk);
    btb_update_en = 1'b0;
    btb_trained   = 1'b1;
  endtask

  initial begin
    seed              = 32'hbfa4;
    error_count       = 0;
    cycle_count       = 0;
    redirect_count    = 0;
    stall_cycles      = 0;
    btb_trained       = 1'b0;
    rst_n             = 1'b0;
    stall             = 1'b0;
    redirect          = 1'b0;
    btb_update_en     = 1'b0;
    btb_update_taken  = 1'b0;
    imem_wen          = 1'b0;
    redirect_pc       = '0;
    btb_update_pc     = '0;
    btb_update_target = '0;
    imem_waddr        = '0;
    imem_wdata        = '0;
    // Reset stays low through the load and for RESET_CYCLES after it
    load_program();
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    run_cycles(20);
    run_random_stalls(60);
    pulse_redirect(32'h0000_0200);
    run_cycles(6);
    train_btb(BRANCH_PC, BRANCH_TARGET);
    // Approach the branch from just below so the prediction is taken
    pulse_redirect(BRANCH_PC - 4);
    run_cycles(24);
    run_random_stalls(40);
    flush_while_stalled(32'h0000_0100);
    run_cycles(10);
    $display("Summary: %0d errors, %0d redirects, %0d stall cycles, %0d cycles",
             error_count, redirect_count, stall_cycles, cycle_count);
    if (error_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // Reset shows a NOP at pc 0 with no prediction
  a_reset_outputs: assert property (
    @(posedge clk) !rst_n |=> instr_id == I_NOP && pc_id == RESET_PC
      && pc_plus4_id == RESET_PC + 4 && !btb_hit_id && !btb_pred_taken_id
  ) else begin
    error_count++;
    $display("ERROR reset instr_id %h pc_id %h pc_plus4_id %h, expected %h %h %h",
             $sampled(instr_id), $sampled(pc_id), $sampled(pc_plus4_id),
             I_NOP, RESET_PC, RESET_PC + 4);
  end

  // The reset vector's word comes out right after release
  a_first_fetch: assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(rst_n) && !stall |=> pc_id == RESET_PC && instr_id == stored_word(RESET_PC)
  ) else begin
    error_count++;
    $display("ERROR first fetch pc_id %h instr_id %h, expected %h %h",
             $sampled(pc_id), $sampled(instr_id), RESET_PC, stored_word(RESET_PC));
  end

  // Any real instruction must be the word stored at its pc
  a_word_matches_pc: assert property (
    @(posedge clk) disable iff (!rst_n)
    instr_id == I_NOP || instr_id == stored_word(pc_id)
  ) else begin
    error_count++;
    $display("ERROR instr_id %h expected %h for pc_id %h",
             $sampled(instr_id), stored_word($sampled(pc_id)), $sampled(pc_id));
  end

  a_plus4: assert property (
    @(posedge clk) disable iff (!rst_n) pc_plus4_id == pc_id + 4
  ) else begin
    error_count++;
    $display("ERROR pc_plus4_id %h expected %h", $sampled(pc_plus4_id), $sampled(pc_id) + 4);
  end

  // Two clean cycles without a taken prediction advance the pc by one word
  a_sequential_step: assert property (
    @(posedge clk) disable iff (!rst_n)
    !stall && !redirect ##1 !stall |=> btb_pred_taken_id || pc_id == prev_pc + 4
  ) else begin
    error_count++;
    $display("ERROR pc_id %h expected %h", $sampled(pc_id), $sampled(prev_pc) + 4);
  end

  // A stall without a flush freezes every output
  a_stall_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    stall && !redirect |=> id_out == prev_out
  ) else begin
    error_count++;
    $display("ERROR id_out %h expected %h during stall", $sampled(id_out), $sampled(prev_out));
  end

  // A flush squashes the next slot, even under a stall
  a_redirect_nop: assert property (
    @(posedge clk) disable iff (!rst_n) redirect |=> instr_id == I_NOP
  ) else begin
    error_count++;
    $display("ERROR instr_id %h expected %h after redirect", $sampled(instr_id), I_NOP);
  end

  a_redirect_target: assert property (
    @(posedge clk) disable iff (!rst_n)
    redirect && !stall ##1 !stall && !redirect
      |=> pc_id == $past(redirect_pc, 2) && instr_id == stored_word(pc_id)
  ) else begin
    error_count++;
    $display("ERROR pc_id %h instr_id %h expected %h %h after redirect",
             $sampled(pc_id), $sampled(instr_id),
             $sampled(redirect_pc), stored_word($sampled(redirect_pc)));
  end

  // The slot fetched on the predicted path carries the prediction
  a_predicted_target: assert property (
    @(posedge clk) disable iff (!rst_n)
    btb_trained && pc_id == BRANCH_PC && !stall && !redirect && !$past(stall)
      && !$past(redirect)
      |=> pc_id == BRANCH_TARGET && btb_hit_id && btb_pred_taken_id
        && btb_target_id == BRANCH_TARGET && instr_id == stored_word(BRANCH_TARGET)
  ) else begin
    error_count++;
    $display("ERROR pc_id %h btb_hit_id %h btb_pred_taken_id %h btb_target_id %h, expected %h 1 1 %h",
             $sampled(pc_id), $sampled(btb_hit_id), $sampled(btb_pred_taken_id),
             $sampled(btb_target_id), BRANCH_TARGET, BRANCH_TARGET);
  end

  // Same index with another tag must miss and fall through sequentially
  a_alias_miss: assert property (
    @(posedge clk) disable iff (!rst_n)
    btb_trained && pc_id[BTB_INDEX_BITS+1:2] == BRANCH_PC[BTB_INDEX_BITS+1:2]
      && pc_id != BRANCH_PC && !stall && !redirect && !$past(stall) && !$past(redirect)
      |=> !btb_hit_id && pc_id == prev_pc + 4
  ) else begin
    error_count++;
    $display("ERROR btb_hit_id %h pc_id %h, expected 0 %h after aliased pc %h",
             $sampled(btb_hit_id), $sampled(pc_id), $sampled(prev_pc) + 4, $sampled(prev_pc));
  end

endmodule

`default_nettype wire
